/* mips_pkg.sv */
package mips_pkg;

	localparam int NB_DATA   = 32;
	localparam int NB_REG    = 5;
	localparam int NB_PC     = 7;
	localparam int NB_OPCODE = 6;

	// primary opcodes
	localparam logic [NB_OPCODE-1:0] OP_RTYPE = 6'h00;
	localparam logic [NB_OPCODE-1:0] OP_J     = 6'h02;
	localparam logic [NB_OPCODE-1:0] OP_BEQ   = 6'h04;
	localparam logic [NB_OPCODE-1:0] OP_BNE   = 6'h05;
	localparam logic [NB_OPCODE-1:0] OP_ADDIU = 6'h09;
	localparam logic [NB_OPCODE-1:0] OP_ANDI  = 6'h0c;
	localparam logic [NB_OPCODE-1:0] OP_ORI   = 6'h0d;
	localparam logic [NB_OPCODE-1:0] OP_LUI   = 6'h0f;

	// funct field, r-type only
	localparam logic [5:0] FN_SLL  = 6'h00;
	localparam logic [5:0] FN_SRL  = 6'h02;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_SLT  = 6'h2a;

	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_OR  = 4'd3,
		ALU_XOR = 4'd4,
		ALU_SLT = 4'd5,
		ALU_SLL = 4'd6,
		ALU_SRL = 4'd7,
		ALU_LUI = 4'd8
	} alu_op_e;

	// same 32 bits, read as r, i or j format
	typedef union packed {
		struct packed {
			logic [NB_OPCODE-1:0] opcode;
			logic [NB_REG-1:0]    rs;
			logic [NB_REG-1:0]    rt;
			logic [NB_REG-1:0]    rd;
			logic [4:0]           shamt;
			logic [5:0]           funct;
		} r;
		struct packed {
			logic [NB_OPCODE-1:0] opcode;
			logic [NB_REG-1:0]    rs;
			logic [NB_REG-1:0]    rt;
			logic [15:0]          imm16;
		} i;
		struct packed {
			logic [NB_OPCODE-1:0] opcode;
			logic [25:0]          target26;
		} j;
	} instr_u;

endpackage

/* decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
	input  logic                          clock_i,
	input  logic                          reset_i,
	input  logic                          instr_valid_i,
	input  mips_pkg::instr_u              instr_i,
	input  logic [mips_pkg::NB_PC-1:0]    pc_i,
	input  logic [mips_pkg::NB_DATA-1:0]  rd_data_a_i,
	input  logic [mips_pkg::NB_DATA-1:0]  rd_data_b_i,
	output logic [mips_pkg::NB_REG-1:0]   rd_addr_a_o,
	output logic [mips_pkg::NB_REG-1:0]   rd_addr_b_o,
	output logic                          d_valid_o,
	output mips_pkg::alu_op_e             d_alu_op_o,
	output logic [mips_pkg::NB_REG-1:0]   d_rs_o,
	output logic [mips_pkg::NB_REG-1:0]   d_rt_o,
	output logic [mips_pkg::NB_DATA-1:0]  d_op_a_o,
	output logic [mips_pkg::NB_DATA-1:0]  d_op_b_o,
	output logic [mips_pkg::NB_DATA-1:0]  d_imm_o,
	output logic [4:0]                    d_shamt_o,
	output logic                          d_use_imm_o,
	output logic [mips_pkg::NB_REG-1:0]   d_dest_o,
	output logic                          d_write_o,
	output logic                          d_is_beq_o,
	output logic                          d_is_bne_o,
	output logic                          d_is_jump_o,
	output logic [mips_pkg::NB_PC-1:0]    d_pc_o,
	output logic [mips_pkg::NB_PC-1:0]    d_jump_offset_o
);
	import mips_pkg::*;

	alu_op_e            alu_op;
	logic               use_imm;
	logic               write_en;
	logic               is_beq;
	logic               is_bne;
	logic               is_jump;
	logic               rtype_dest;
	logic               sign_ext;
	logic [NB_DATA-1:0] imm_ext;
	logic [NB_REG-1:0]  dest;

	// register file is read straight from the incoming word
	assign rd_addr_a_o = instr_i.r.rs;
	assign rd_addr_b_o = instr_i.r.rt;

	always_comb begin
		alu_op     = ALU_ADD;
		use_imm    = 1'b0;
		write_en   = 1'b0;
		is_beq     = 1'b0;
		is_bne     = 1'b0;
		is_jump    = 1'b0;
		rtype_dest = 1'b0;
		sign_ext   = 1'b0;
		case (instr_i.r.opcode)
			OP_RTYPE: begin
				write_en   = 1'b1;
				rtype_dest = 1'b1;
				case (instr_i.r.funct)
					FN_ADDU: alu_op = ALU_ADD;
					FN_SUBU: alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_XOR:  alu_op = ALU_XOR;
					FN_SLT:  alu_op = ALU_SLT;
					FN_SLL:  alu_op = ALU_SLL;
					FN_SRL:  alu_op = ALU_SRL;
					// unknown funct is dropped
					default: write_en = 1'b0;
				endcase
			end
			OP_ADDIU: begin
				alu_op   = ALU_ADD;
				use_imm  = 1'b1;
				write_en = 1'b1;
				sign_ext = 1'b1;
			end
			OP_ANDI: begin
				alu_op   = ALU_AND;
				use_imm  = 1'b1;
				write_en = 1'b1;
			end
			OP_ORI: begin
				alu_op   = ALU_OR;
				use_imm  = 1'b1;
				write_en = 1'b1;
			end
			OP_LUI: begin
				alu_op   = ALU_LUI;
				use_imm  = 1'b1;
				write_en = 1'b1;
			end
			OP_BEQ: begin
				is_beq   = 1'b1;
				sign_ext = 1'b1;
			end
			OP_BNE: begin
				is_bne   = 1'b1;
				sign_ext = 1'b1;
			end
			OP_J:    is_jump = 1'b1;
			default: ;
		endcase
	end

	assign imm_ext = sign_ext ? {{(NB_DATA-16){instr_i.i.imm16[15]}}, instr_i.i.imm16}
	                          : {{(NB_DATA-16){1'b0}}, instr_i.i.imm16};

	assign dest = rtype_dest ? instr_i.r.rd : instr_i.i.rt;

	// flags only live with a valid word
	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			d_valid_o   <= 1'b0;
			d_write_o   <= 1'b0;
			d_is_beq_o  <= 1'b0;
			d_is_bne_o  <= 1'b0;
			d_is_jump_o <= 1'b0;
		end else begin
			d_valid_o   <= instr_valid_i;
			d_write_o   <= instr_valid_i & write_en;
			d_is_beq_o  <= instr_valid_i & is_beq;
			d_is_bne_o  <= instr_valid_i & is_bne;
			d_is_jump_o <= instr_valid_i & is_jump;
		end
	end

	always_ff @(posedge clock_i) begin
		d_alu_op_o      <= alu_op;
		d_rs_o          <= instr_i.r.rs;
		d_rt_o          <= instr_i.r.rt;
		d_op_a_o        <= rd_data_a_i;
		d_op_b_o        <= rd_data_b_i;
		d_imm_o         <= imm_ext;
		d_shamt_o       <= instr_i.r.shamt;
		d_use_imm_o     <= use_imm;
		d_dest_o        <= dest;
		d_pc_o          <= pc_i;
		d_jump_offset_o <= instr_i.j.target26[NB_PC-1:0];
	end

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
	input  logic                          clock_i,
	input  logic                          reset_i,
	input  logic                          d_valid_i,
	input  mips_pkg::alu_op_e             d_alu_op_i,
	input  logic [mips_pkg::NB_REG-1:0]   d_rs_i,
	input  logic [mips_pkg::NB_REG-1:0]   d_rt_i,
	input  logic [mips_pkg::NB_DATA-1:0]  d_op_a_i,
	input  logic [mips_pkg::NB_DATA-1:0]  d_op_b_i,
	input  logic [mips_pkg::NB_DATA-1:0]  d_imm_i,
	input  logic [4:0]                    d_shamt_i,
	input  logic                          d_use_imm_i,
	input  logic [mips_pkg::NB_REG-1:0]   d_dest_i,
	input  logic                          d_write_i,
	input  logic                          d_is_beq_i,
	input  logic                          d_is_bne_i,
	input  logic                          d_is_jump_i,
	input  logic [mips_pkg::NB_PC-1:0]    d_pc_i,
	input  logic [mips_pkg::NB_PC-1:0]    d_jump_offset_i,
	input  logic                          w_valid_i,
	input  logic                          w_write_i,
	input  logic [mips_pkg::NB_REG-1:0]   w_dest_i,
	input  logic [mips_pkg::NB_DATA-1:0]  w_data_i,
	output logic                          e_valid_o,
	output logic                          e_write_o,
	output logic [mips_pkg::NB_REG-1:0]   e_dest_o,
	output logic [mips_pkg::NB_DATA-1:0]  e_result_o,
	output logic                          branch_valid_o,
	output logic                          branch_taken_o,
	output logic [mips_pkg::NB_PC-1:0]    branch_target_o
);
	import mips_pkg::*;

	logic               e_hit;
	logic               w_hit;
	logic [NB_DATA-1:0] op_a;
	logic [NB_DATA-1:0] op_b;
	logic [NB_DATA-1:0] alu_b;
	logic [NB_DATA-1:0] alu_result;
	logic               operands_equal;
	logic               taken;
	logic [NB_PC-1:0]   target;

	// newest producer wins, r0 never forwards
	function automatic logic [NB_DATA-1:0] forward(
		input logic [NB_REG-1:0]  src,
		input logic [NB_DATA-1:0] reg_value
	);
		if (e_hit && e_dest_o == src)
			return e_result_o;
		else if (w_hit && w_dest_i == src)
			return w_data_i;
		else
			return reg_value;
	endfunction

	assign e_hit = e_valid_o & e_write_o & (e_dest_o != '0);
	assign w_hit = w_valid_i & w_write_i & (w_dest_i != '0);

	always_comb begin
		op_a = forward(d_rs_i, d_op_a_i);
		op_b = forward(d_rt_i, d_op_b_i);
	end

	assign alu_b = d_use_imm_i ? d_imm_i : op_b;

	always_comb begin
		case (d_alu_op_i)
			ALU_ADD: alu_result = op_a + alu_b;
			ALU_SUB: alu_result = op_a - alu_b;
			ALU_AND: alu_result = op_a & alu_b;
			ALU_OR:  alu_result = op_a | alu_b;
			ALU_XOR: alu_result = op_a ^ alu_b;
			ALU_SLT: alu_result = {{(NB_DATA-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
			// shifts act on rt
			ALU_SLL: alu_result = op_b << d_shamt_i;
			ALU_SRL: alu_result = op_b >> d_shamt_i;
			ALU_LUI: alu_result = {d_imm_i[NB_DATA/2-1:0], {(NB_DATA/2){1'b0}}};
			default: alu_result = '0;
		endcase
	end

	assign operands_equal = (op_a == op_b);
	assign taken = d_is_jump_i | (d_is_beq_i & operands_equal) | (d_is_bne_i & ~operands_equal);

	// branch offset counts from pc+1, jump adds the raw low bits
	assign target = d_is_jump_i ? d_pc_i + d_jump_offset_i
	                            : d_pc_i + NB_PC'(1) + d_imm_i[NB_PC-1:0];

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			e_valid_o      <= 1'b0;
			e_write_o      <= 1'b0;
			branch_valid_o <= 1'b0;
			branch_taken_o <= 1'b0;
		end else begin
			e_valid_o      <= d_valid_i;
			e_write_o      <= d_valid_i & d_write_i;
			branch_valid_o <= d_valid_i & (d_is_beq_i | d_is_bne_i | d_is_jump_i);
			branch_taken_o <= d_valid_i & taken;
		end
	end

	always_ff @(posedge clock_i) begin
		e_dest_o        <= d_dest_i;
		e_result_o      <= alu_result;
		branch_target_o <= target;
	end

endmodule

/* result_stage.sv */
`timescale 1ns/1ps

module result_stage (
	input  logic                          clock_i,
	input  logic                          reset_i,
	input  logic                          e_valid_i,
	input  logic                          e_write_i,
	input  logic [mips_pkg::NB_REG-1:0]   e_dest_i,
	input  logic [mips_pkg::NB_DATA-1:0]  e_result_i,
	input  logic [mips_pkg::NB_REG-1:0]   rd_addr_a_i,
	input  logic [mips_pkg::NB_REG-1:0]   rd_addr_b_i,
	output logic [mips_pkg::NB_DATA-1:0]  rd_data_a_o,
	output logic [mips_pkg::NB_DATA-1:0]  rd_data_b_o,
	output logic                          w_valid_o,
	output logic                          w_write_o,
	output logic [mips_pkg::NB_REG-1:0]   w_dest_o,
	output logic [mips_pkg::NB_DATA-1:0]  w_data_o,
	output logic                          wb_valid_o,
	output logic [mips_pkg::NB_REG-1:0]   wb_addr_o,
	output logic [mips_pkg::NB_DATA-1:0]  wb_data_o
);
	import mips_pkg::*;

	logic [NB_DATA-1:0] regs [2**NB_REG];
	logic               w_commit;

	// pending write seen by a read in the same cycle
	function automatic logic [NB_DATA-1:0] read_port(input logic [NB_REG-1:0] addr);
		if (addr == '0)
			return '0;
		else if (w_commit && w_dest_o == addr)
			return w_data_o;
		else
			return regs[addr];
	endfunction

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			w_valid_o <= 1'b0;
			w_write_o <= 1'b0;
		end else begin
			w_valid_o <= e_valid_i;
			w_write_o <= e_valid_i & e_write_i;
		end
	end

	always_ff @(posedge clock_i) begin
		w_dest_o <= e_dest_i;
		w_data_o <= e_result_i;
	end

	assign w_commit = w_valid_o & w_write_o & (w_dest_o != '0);

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			for (int i = 0; i < 2**NB_REG; i++)
				regs[i] <= '0;
		end else if (w_commit) begin
			regs[w_dest_o] <= w_data_o;
		end
	end

	always_comb begin
		rd_data_a_o = read_port(rd_addr_a_i);
		rd_data_b_o = read_port(rd_addr_b_i);
	end

	assign wb_valid_o = w_commit;
	assign wb_addr_o  = w_dest_o;
	assign wb_data_o  = w_data_o;

endmodule

/* core_top.sv */
`timescale 1ns/1ps

module core_top (
	input  logic                          clock_i,
	input  logic                          reset_i,
	input  logic                          instr_valid_i,
	input  mips_pkg::instr_u              instr_i,
	input  logic [mips_pkg::NB_PC-1:0]    pc_i,
	output logic                          wb_valid_o,
	output logic [mips_pkg::NB_REG-1:0]   wb_addr_o,
	output logic [mips_pkg::NB_DATA-1:0]  wb_data_o,
	output logic                          branch_valid_o,
	output logic                          branch_taken_o,
	output logic [mips_pkg::NB_PC-1:0]    branch_target_o
);
	import mips_pkg::*;

	// register file read path
	logic [NB_REG-1:0]  rd_addr_a;
	logic [NB_REG-1:0]  rd_addr_b;
	logic [NB_DATA-1:0] rd_data_a;
	logic [NB_DATA-1:0] rd_data_b;

	// decode register
	logic               d_valid;
	alu_op_e            d_alu_op;
	logic [NB_REG-1:0]  d_rs;
	logic [NB_REG-1:0]  d_rt;
	logic [NB_DATA-1:0] d_op_a;
	logic [NB_DATA-1:0] d_op_b;
	logic [NB_DATA-1:0] d_imm;
	logic [4:0]         d_shamt;
	logic               d_use_imm;
	logic [NB_REG-1:0]  d_dest;
	logic               d_write;
	logic               d_is_beq;
	logic               d_is_bne;
	logic               d_is_jump;
	logic [NB_PC-1:0]   d_pc;
	logic [NB_PC-1:0]   d_jump_offset;

	// execute register
	logic               e_valid;
	logic               e_write;
	logic [NB_REG-1:0]  e_dest;
	logic [NB_DATA-1:0] e_result;

	// result register, also the second forwarding source
	logic               w_valid;
	logic               w_write;
	logic [NB_REG-1:0]  w_dest;
	logic [NB_DATA-1:0] w_data;

	decode_stage decode_inst (
		.clock_i         (clock_i),
		.reset_i         (reset_i),
		.instr_valid_i   (instr_valid_i),
		.instr_i         (instr_i),
		.pc_i            (pc_i),
		.rd_data_a_i     (rd_data_a),
		.rd_data_b_i     (rd_data_b),
		.rd_addr_a_o     (rd_addr_a),
		.rd_addr_b_o     (rd_addr_b),
		.d_valid_o       (d_valid),
		.d_alu_op_o      (d_alu_op),
		.d_rs_o          (d_rs),
		.d_rt_o          (d_rt),
		.d_op_a_o        (d_op_a),
		.d_op_b_o        (d_op_b),
		.d_imm_o         (d_imm),
		.d_shamt_o       (d_shamt),
		.d_use_imm_o     (d_use_imm),
		.d_dest_o        (d_dest),
		.d_write_o       (d_write),
		.d_is_beq_o      (d_is_beq),
		.d_is_bne_o      (d_is_bne),
		.d_is_jump_o     (d_is_jump),
		.d_pc_o          (d_pc),
		.d_jump_offset_o (d_jump_offset)
	);

	execute_stage execute_inst (
		.clock_i         (clock_i),
		.reset_i         (reset_i),
		.d_valid_i       (d_valid),
		.d_alu_op_i      (d_alu_op),
		.d_rs_i          (d_rs),
		.d_rt_i          (d_rt),
		.d_op_a_i        (d_op_a),
		.d_op_b_i        (d_op_b),
		.d_imm_i         (d_imm),
		.d_shamt_i       (d_shamt),
		.d_use_imm_i     (d_use_imm),
		.d_dest_i        (d_dest),
		.d_write_i       (d_write),
		.d_is_beq_i      (d_is_beq),
		.d_is_bne_i      (d_is_bne),
		.d_is_jump_i     (d_is_jump),
		.d_pc_i          (d_pc),
		.d_jump_offset_i (d_jump_offset),
		.w_valid_i       (w_valid),
		.w_write_i       (w_write),
		.w_dest_i        (w_dest),
		.w_data_i        (w_data),
		.e_valid_o       (e_valid),
		.e_write_o       (e_write),
		.e_dest_o        (e_dest),
		.e_result_o      (e_result),
		.branch_valid_o  (branch_valid_o),
		.branch_taken_o  (branch_taken_o),
		.branch_target_o (branch_target_o)
	);

	result_stage result_inst (
		.clock_i     (clock_i),
		.reset_i     (reset_i),
		.e_valid_i   (e_valid),
		.e_write_i   (e_write),
		.e_dest_i    (e_dest),
		.e_result_i  (e_result),
		.rd_addr_a_i (rd_addr_a),
		.rd_addr_b_i (rd_addr_b),
		.rd_data_a_o (rd_data_a),
		.rd_data_b_o (rd_data_b),
		.w_valid_o   (w_valid),
		.w_write_o   (w_write),
		.w_dest_o    (w_dest),
		.w_data_o    (w_data),
		.wb_valid_o  (wb_valid_o),
		.wb_addr_o   (wb_addr_o),
		.wb_data_o   (wb_data_o)
	);

endmodule

/* core_properties.sv */
`timescale 1ns/1ps

module core_properties (
	input logic clock_i,
	input logic reset_i,
	input logic d_valid_i,
	input logic d_is_beq_i,
	input logic d_is_bne_i,
	input logic d_is_jump_i,
	input logic e_valid_i,
	input logic w_valid_i,
	input logic branch_valid_i
);

	logic d_branch;

	assign d_branch = d_valid_i & (d_is_beq_i | d_is_bne_i | d_is_jump_i);

	// a reset edge clears the report register
	no_branch_in_reset: assert property (@(posedge clock_i) reset_i |=> !branch_valid_i)
		else $error("branch report seen during reset");

	execute_to_result: assert property (@(posedge clock_i) disable iff (reset_i)
		e_valid_i |=> w_valid_i)
		else $error("execute valid not followed by result valid");

	branch_after_decode: assert property (@(posedge clock_i) disable iff (reset_i)
		d_branch |=> branch_valid_i)
		else $error("decoded branch gave no report one cycle later");

	// and no report without a decoded branch
	branch_has_source: assert property (@(posedge clock_i) disable iff (reset_i)
		branch_valid_i |-> $past(d_branch))
		else $error("branch report without a decoded branch");

endmodule

/* core_tb.sv */
`timescale 1ns/1ps

module core_tb;
	import mips_pkg::*;

	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 16;
	localparam int IDLE_CYCLES  = 8;
	localparam int NUM_SLOTS    = 3000;
	localparam int DRAIN_CYCLES = 6;

	logic               clock;
	logic               reset;
	logic               instr_valid;
	instr_u             instr;
	logic [NB_PC-1:0]   pc;
	logic               wb_valid;
	logic [NB_REG-1:0]  wb_addr;
	logic [NB_DATA-1:0] wb_data;
	logic               branch_valid;
	logic               branch_taken;
	logic [NB_PC-1:0]   branch_target;

	integer             seed;
	int                 errors;
	int                 other_errors;
	int                 checks;
	int                 cyc;
	instr_u             word;
	logic [NB_PC-1:0]   issue_pc;
	logic [NB_DATA-1:0] model_regs [32];

	// expected events, in issue order
	logic [NB_REG-1:0]  exp_wb_addr [$];
	logic [NB_DATA-1:0] exp_wb_data [$];
	int                 exp_wb_cycle [$];
	logic               exp_br_taken [$];
	logic [NB_PC-1:0]   exp_br_target [$];
	int                 exp_br_cycle [$];

	core_top core_top_inst (
		.clock_i         (clock),
		.reset_i         (reset),
		.instr_valid_i   (instr_valid),
		.instr_i         (instr),
		.pc_i            (pc),
		.wb_valid_o      (wb_valid),
		.wb_addr_o       (wb_addr),
		.wb_data_o       (wb_data),
		.branch_valid_o  (branch_valid),
		.branch_taken_o  (branch_taken),
		.branch_target_o (branch_target)
	);

	bind execute_stage core_properties props_inst (
		.clock_i        (clock_i),
		.reset_i        (reset_i),
		.d_valid_i      (d_valid_i),
		.d_is_beq_i     (d_is_beq_i),
		.d_is_bne_i     (d_is_bne_i),
		.d_is_jump_i    (d_is_jump_i),
		.e_valid_i      (e_valid_o),
		.w_valid_i      (w_valid_i),
		.branch_valid_i (branch_valid_o)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD/2) clock = ~clock;
	end

	initial begin
		#((NUM_SLOTS + 50) * CLK_PERIOD);
		$display("Timeout: the run did not end within %0d cycles", NUM_SLOTS + 50);
		$display("Verification failed");
		$finish;
	end

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// mostly r0..r7 so results get reused soon
	function automatic logic [NB_REG-1:0] pick_reg();
		if (rand_below(4) != 0)
			return NB_REG'(rand_below(8));
		else
			return NB_REG'(rand_below(32));
	endfunction

	// kinds 0..7 r-type, 8..13 i-type, 14 jump
	function automatic instr_u make_instr(input int kind);
		instr_u w;
		w = '0;
		if (kind < 8) begin
			w.r.opcode = OP_RTYPE;
			w.r.rs     = pick_reg();
			w.r.rt     = pick_reg();
			w.r.rd     = pick_reg();
			w.r.shamt  = 5'(rand_below(32));
			case (kind)
				0:       w.r.funct = FN_ADDU;
				1:       w.r.funct = FN_SUBU;
				2:       w.r.funct = FN_AND;
				3:       w.r.funct = FN_OR;
				4:       w.r.funct = FN_XOR;
				5:       w.r.funct = FN_SLT;
				6:       w.r.funct = FN_SLL;
				default: w.r.funct = FN_SRL;
			endcase
		end else if (kind < 14) begin
			case (kind)
				8:       w.i.opcode = OP_ADDIU;
				9:       w.i.opcode = OP_ANDI;
				10:      w.i.opcode = OP_ORI;
				11:      w.i.opcode = OP_LUI;
				12:      w.i.opcode = OP_BEQ;
				default: w.i.opcode = OP_BNE;
			endcase
			w.i.rs    = pick_reg();
			w.i.rt    = pick_reg();
			w.i.imm16 = 16'($random(seed));
		end else begin
			w.j.opcode   = OP_J;
			w.j.target26 = 26'($random(seed));
		end
		return w;
	endfunction

	task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
	                       input string what);
		checks++;
		if (actual !== expected) begin
			$display("Error at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
			errors++;
		end
	endtask

	// executes one instruction in order at issue time
	task automatic run_model(input instr_u w, input logic [NB_PC-1:0] at_pc, input int at_cyc);
		logic [NB_DATA-1:0] a;
		logic [NB_DATA-1:0] b;
		logic [NB_DATA-1:0] imm_s;
		logic [NB_DATA-1:0] imm_z;
		logic [NB_DATA-1:0] res;
		logic [NB_REG-1:0]  dest;
		logic               writes;
		logic               branch;
		logic               taken;
		logic [NB_PC-1:0]   target;
		a      = model_regs[w.r.rs];
		b      = model_regs[w.r.rt];
		imm_s  = {{16{w.i.imm16[15]}}, w.i.imm16};
		imm_z  = {16'h0000, w.i.imm16};
		res    = '0;
		dest   = w.i.rt;
		writes = 1'b1;
		branch = 1'b0;
		taken  = 1'b0;
		target = '0;
		case (w.r.opcode)
			OP_RTYPE: begin
				dest = w.r.rd;
				case (w.r.funct)
					FN_ADDU: res = a + b;
					FN_SUBU: res = a - b;
					FN_AND:  res = a & b;
					FN_OR:   res = a | b;
					FN_XOR:  res = a ^ b;
					FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					FN_SLL:  res = b << w.r.shamt;
					FN_SRL:  res = b >> w.r.shamt;
					default: writes = 1'b0;
				endcase
			end
			OP_ADDIU: res = a + imm_s;
			OP_ANDI:  res = a & imm_z;
			OP_ORI:   res = a | imm_z;
			OP_LUI:   res = {w.i.imm16, 16'h0000};
			OP_BEQ, OP_BNE: begin
				writes = 1'b0;
				branch = 1'b1;
				taken  = (w.r.opcode == OP_BEQ) ? (a == b) : (a != b);
				// offset from the next word, wraps at 7 bits
				target = at_pc + 7'd1 + imm_s[NB_PC-1:0];
			end
			OP_J: begin
				writes = 1'b0;
				branch = 1'b1;
				taken  = 1'b1;
				target = at_pc + w.j.target26[NB_PC-1:0];
			end
			default: writes = 1'b0;
		endcase
		if (writes && dest != '0) begin
			model_regs[dest] = res;
			exp_wb_addr.push_back(dest);
			exp_wb_data.push_back(res);
			exp_wb_cycle.push_back(at_cyc + 3);
		end
		if (branch) begin
			exp_br_taken.push_back(taken);
			exp_br_target.push_back(target);
			exp_br_cycle.push_back(at_cyc + 2);
		end
	endtask

	task automatic check_outputs(input int at_cyc);
		if (wb_valid) begin
			if (exp_wb_addr.size() == 0) begin
				$display("Write pulse to r%0d at %0d ns while no write was expected",
				         wb_addr, $time);
				other_errors++;
			end else begin
				compare(wb_addr, exp_wb_addr.pop_front(), "write address");
				compare(wb_data, exp_wb_data.pop_front(), "write data");
				compare(at_cyc, exp_wb_cycle.pop_front(), "write cycle");
			end
		end
		if (branch_valid) begin
			if (exp_br_taken.size() == 0) begin
				$display("Branch pulse at %0d ns while no branch was expected", $time);
				other_errors++;
			end else begin
				compare(branch_taken, exp_br_taken.pop_front(), "branch taken");
				compare(branch_target, exp_br_target.pop_front(), "branch target");
				compare(at_cyc, exp_br_cycle.pop_front(), "branch cycle");
			end
		end
	endtask

	initial begin
		seed         = 32'h8c13;
		errors       = 0;
		other_errors = 0;
		checks       = 0;
		reset        = 1'b1;
		instr_valid  = 1'b0;
		instr        = '0;
		pc           = '0;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		repeat (RESET_CYCLES) @(negedge clock);
		reset = 1'b0;
		cyc   = 0;
		// quiet period, nothing may come out
		repeat (IDLE_CYCLES) begin
			@(negedge clock);
			check_outputs(cyc);
			cyc++;
		end
		for (int s = 0; s < NUM_SLOTS + DRAIN_CYCLES; s++) begin
			@(negedge clock);
			check_outputs(cyc);
			if (s < NUM_SLOTS && rand_below(4) != 0) begin
				word     = make_instr(rand_below(15));
				issue_pc = NB_PC'(rand_below(128));
				run_model(word, issue_pc, cyc);
				instr_valid = 1'b1;
				instr       = word;
				pc          = issue_pc;
			end else begin
				// garbage on the bus while idle
				instr_valid = 1'b0;
				instr       = $random(seed);
				pc          = NB_PC'(rand_below(128));
			end
			cyc++;
		end
		if (exp_wb_addr.size() != 0) begin
			$display("%0d expected writes never arrived", exp_wb_addr.size());
			other_errors++;
		end
		if (exp_br_taken.size() != 0) begin
			$display("%0d expected branch reports never arrived", exp_br_taken.size());
			other_errors++;
		end
		$display("Summary: %0d checks, %0d value errors, %0d other failures",
		         checks, errors, other_errors);
		if (errors == 0 && other_errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* tb.f */
mips_pkg.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
core_top.sv
core_properties.sv
core_tb.sv

/* Bender.yml */
package:
  name: mips_core_slice

sources:
  - mips_pkg.sv
  - decode_stage.sv
  - execute_stage.sv
  - result_stage.sv
  - core_top.sv
  - target: test
    files:
      - core_properties.sv
      - core_tb.sv
